// File: dv/core_stimulus.txt
// op  addr_or_value  data_or_expected, three hex words per operation
// 1 WR, 2 RD, 3 IN, 4 PPS, 5 PIN (ctrl, leds), 6 RDERR, 7 WRERR, 8 RDRNG, 9 RDGT, 0 END
3 0000001F 00000000   // all hardware inputs high
5 00000001 0000001E   // reset state
1 00007000 0000001F   // clock: ready, both enables, sel 3
5 00003E01 0000001E
1 00007004 0000000A   // SERDES enable and loopback
5 00003F41 0000001E
1 00007008 00000005   // ADC A and B powered, outputs off
5 00003F4B 0000001E
1 00007010 00000001   // PHY into reset
5 00003F4A 0000001E
1 00007014 FFFFFFFF   // unused setting address
5 00003F4A 0000001E
1 00007010 00000000   // PHY out of reset
5 00003F4B 0000001E
1 0000700C 000000A5   // LED software value
1 00007018 0000000F   // low nibble from hardware
3 0000000A 00000000   // run_rx and link_up only
5 00003F4B 000000AA
3 00000015 00000000   // run_tx, clk_status and button
5 00003F4B 000000A4
2 00005C10 00080002   // compatibility number
2 00005C14 00002800   // button and clk_status
3 0000000E 00000000
2 00005C14 00000C00   // clk_status and link_up
2 00005C18 00000000
2 00005C1C 00000000
1 00007028 12345678   // time high, held
1 0000702C 00001000   // time low, loads both
4 00000000 00000000
2 00005C08 12345678   // PPS time high
8 00005C0C 00001000   // PPS time low within 200 counts
9 00005C04 00000000   // live time low is later
6 00001000 00000000   // unmapped read
7 00001004 DEADBEEF   // unmapped write
2 00005C10 00080002   // bus still usable
1 00007004 00000000
5 00003E0B 000000AE
0 00000000 00000000

// File: dv/radio_core_assertions.sv
/*
 * Wishbone and settings-strobe rules, bound into the core's top level.
 * Assumes a single master that holds its request until ack or err.
 */
`timescale 1ns/1ps
`include "core_params.svh"

module radio_core_assertions (
   input logic               dsp_clk,
   input logic               por_rst,
   input core_pkg::wb_req_t  wb_req_i,
   input core_pkg::wb_rsp_t  wb_rsp_i,
   input core_pkg::set_bus_t set_bus_i
);

   logic unmapped;

   assign unmapped = ((wb_req_i.adr & `MASK_SETTINGS) != `ADR_SETTINGS) &&
                     ((wb_req_i.adr & `MASK_READBACK) != `ADR_READBACK);

   // Response lands one edge after the request was sampled
   ack_needs_stb: assert property (@(posedge dsp_clk) disable iff (por_rst)
      wb_rsp_i.ack |-> $past(wb_req_i.cyc && wb_req_i.stb))
      else $error("ack seen without a pending cyc and stb");

   ack_err_excl: assert property (@(posedge dsp_clk) disable iff (por_rst)
      !(wb_rsp_i.ack && wb_rsp_i.err))
      else $error("ack and err high in the same cycle");

   set_stb_single: assert property (@(posedge dsp_clk) disable iff (por_rst)
      set_bus_i.stb |=> !set_bus_i.stb)
      else $error("settings stb held for two cycles");

   err_only_unmapped: assert property (@(posedge dsp_clk) disable iff (por_rst)
      wb_rsp_i.err |-> $past(wb_req_i.cyc && wb_req_i.stb && unmapped))
      else $error("err returned for a mapped address");

endmodule

bind radio_core_top radio_core_assertions u_assertions (
   .dsp_clk(dsp_clk),
   .por_rst(por_rst),
   .wb_req_i(wb_req_i),
   .wb_rsp_i(wb_rsp_o),
   .set_bus_i(set_bus)
);

// File: dv/radio_core_tb.sv
/*
 * Testbench for the control-plane core, run from the project root.
 * Operations come from dv/core_stimulus.txt, three hex words each.
 * Single Wishbone master, no retries, one idle cycle between accesses.
 */
`timescale 1ns/1ps

module radio_core_tb;

   import core_pkg::*;

   localparam int CLK_HALF    = 2;
   localparam int DRIVE_DLY   = 1;    // Inputs change after the edge
   localparam int MAX_OPS     = 80;
   localparam int RSP_CYCLES  = 8;
   localparam int CYCLES_OP   = 40;   // Watchdog budget per operation

   localparam logic [31:0] OP_END   = 32'h0;
   localparam logic [31:0] OP_WR    = 32'h1;
   localparam logic [31:0] OP_RD    = 32'h2;
   localparam logic [31:0] OP_IN    = 32'h3;
   localparam logic [31:0] OP_PPS   = 32'h4;
   localparam logic [31:0] OP_PIN   = 32'h5;
   localparam logic [31:0] OP_RDERR = 32'h6;
   localparam logic [31:0] OP_WRERR = 32'h7;
   localparam logic [31:0] OP_RDRNG = 32'h8;
   localparam logic [31:0] OP_RDGT  = 32'h9;

   logic        dsp_clk;
   logic        por_rst;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   logic        pps;
   logic        run_tx;
   logic        run_rx;
   logic        clk_status;
   logic        link_up;
   logic        button;
   ctrl_pins_t  ctrl;
   logic [7:0]  leds;

   logic [31:0] stim [256];
   int          n_ops;
   bit          ops_loaded;
   int          n_checks;
   int          n_errors;
   logic [31:0] saved_word;   // PPS low word for the later compare

   radio_core_top UUT (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp),
      .pps_i(pps), .run_tx_i(run_tx), .run_rx_i(run_rx), .clk_status_i(clk_status),
      .link_up_i(link_up), .button_i(button), .ctrl_o(ctrl), .leds_o(leds)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #CLK_HALF dsp_clk = ~dsp_clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      n_checks++;
      if (actual !== expected) begin
         n_errors++;
         $display("Error: %s expected %h actual %h", name, expected, actual);
      end
   endtask

   function automatic string op_name(input logic [31:0] op);
      case (op)
         OP_WR:    return "write";
         OP_RD:    return "read";
         OP_IN:    return "inputs";
         OP_PPS:   return "pps";
         OP_PIN:   return "pins";
         OP_RDERR: return "unmapped read";
         OP_WRERR: return "unmapped write";
         OP_RDRNG: return "read range";
         OP_RDGT:  return "read later";
         default:  return "unknown";
      endcase
   endfunction

   task automatic load_stimulus();
      int k;
      $readmemh("dv/core_stimulus.txt", stim);
      k = 0;
      while (k < MAX_OPS && stim[8'(3 * k)] != OP_END) k++;
      n_ops = k;
      ops_loaded = 1'b1;
   endtask

   // One Wishbone classic cycle, returns at a drive point
   task automatic bus_cycle(input logic is_write, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic got_ack, output logic got_err);
      int waited;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = is_write;
      wb_req.adr = addr[15:0];
      wb_req.dat = wdata;
      wb_req.sel = 4'hF;
      got_ack = 1'b0;
      got_err = 1'b0;
      rdata   = '0;
      waited  = 0;
      while (!got_ack && !got_err && waited < RSP_CYCLES) begin
         @(posedge dsp_clk);
         #DRIVE_DLY;
         waited++;
         got_ack = wb_rsp.ack;
         got_err = wb_rsp.err;
         rdata   = wb_rsp.dat;
      end
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      wb_req.we  = 1'b0;
      if (!got_ack && !got_err) begin
         n_errors++;
         $display("No ack or err within %0d cycles for address %h", RSP_CYCLES, addr[15:0]);
      end
      @(posedge dsp_clk);   // Idle cycle
      #DRIVE_DLY;
   endtask

   task automatic set_inputs(input logic [4:0] value);
      run_tx     = value[4];
      run_rx     = value[3];
      clk_status = value[2];
      link_up    = value[1];
      button     = value[0];
   endtask

   task automatic pulse_pps();
      pps = 1'b1;
      repeat (3) @(posedge dsp_clk);
      #DRIVE_DLY;
      pps = 1'b0;
      repeat (6) @(posedge dsp_clk);   // Sync, edge detect and latch
      #DRIVE_DLY;
   endtask

   task automatic run_op(input logic [7:0] base, input int line);
      logic [31:0] op;
      logic [31:0] arg;
      logic [31:0] val;
      logic [31:0] rdata;
      logic        got_ack;
      logic        got_err;
      string       name;
      op   = stim[base];
      arg  = stim[base + 8'd1];
      val  = stim[base + 8'd2];
      name = $sformatf("op %0d (%s)", line, op_name(op));
      case (op)
         OP_WR: begin
            bus_cycle(1'b1, arg, val, rdata, got_ack, got_err);
            check_value({name, " ack"}, 32'd1, {31'b0, got_ack});
         end
         OP_RD: begin
            bus_cycle(1'b0, arg, '0, rdata, got_ack, got_err);
            check_value({name, " ack"}, 32'd1, {31'b0, got_ack});
            check_value(name, val, rdata);
         end
         OP_IN:  set_inputs(arg[4:0]);
         OP_PPS: pulse_pps();
         OP_PIN: begin
            @(posedge dsp_clk);
            #DRIVE_DLY;
            check_value({name, " ctrl"}, arg, {18'b0, ctrl});
            check_value({name, " leds"}, val, {24'b0, leds});
         end
         OP_RDERR, OP_WRERR: begin
            bus_cycle(op == OP_WRERR, arg, val, rdata, got_ack, got_err);
            check_value({name, " err"}, 32'd1, {31'b0, got_err});
            check_value({name, " ack"}, 32'd0, {31'b0, got_ack});
         end
         OP_RDRNG: begin
            bus_cycle(1'b0, arg, '0, rdata, got_ack, got_err);
            check_value(name, 32'd1, {31'b0, (rdata >= val && rdata <= val + 32'd200)});
            saved_word = rdata;
         end
         OP_RDGT: begin
            bus_cycle(1'b0, arg, '0, rdata, got_ack, got_err);
            check_value(name, 32'd1, {31'b0, (rdata > saved_word)});
         end
         default: begin
            n_errors++;
            $display("Unknown operation %h on stimulus entry %0d", op, line);
         end
      endcase
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence and watchdog

   initial begin
      por_rst    = 1'b1;
      wb_req     = '0;
      pps        = 1'b0;
      set_inputs(5'b0);
      n_checks   = 0;
      n_errors   = 0;
      saved_word = '0;
      ops_loaded = 1'b0;
      load_stimulus();
      repeat (2) @(posedge dsp_clk);
      #DRIVE_DLY;
      por_rst = 1'b0;
      if (n_ops == 0) begin
         n_errors++;
         $display("Stimulus file holds no operations");
      end
      for (int k = 0; k < n_ops; k++) run_op(8'(3 * k), k + 1);
      $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   initial begin
      wait (ops_loaded);
      repeat (n_ops * CYCLES_OP + 20) @(posedge dsp_clk);
      $display("Watchdog expired, the stimulus did not complete in time");
      $display("TB FAILED");
      $finish;
   end

endmodule

// File: hdl/core_pkg.sv
/*
 * Bus and control-pin types shared by the control-plane core.
 * Wishbone addresses are byte addresses, data is 32 bits wide.
 * Control pins are plain levels with no polarity handling here.
 */
package core_pkg;

   // Master side of one Wishbone classic cycle
   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [15:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
   } wb_req_t;

   // Slave side, ack and err are single-cycle pulses
   typedef struct packed {
      logic        ack;
      logic        err;
      logic [31:0] dat;
   } wb_rsp_t;

   // One settings write, stb is high for exactly one cycle
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // Board control outputs
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
      logic       phy_resetn;   // Active low
   } ctrl_pins_t;

   typedef logic [63:0] vita_time_t;

endpackage

// File: hdl/misc_settings.sv
/*
 * Settings register bank for the clock, SERDES, ADC and PHY pins and LEDs.
 * Registers update on the edge that samples the settings stb.
 * LED source bit 1 selects the hardware indicator, 0 the software value.
 * PHY reset register is active high, the pin is active low.
 */
`timescale 1ns/1ps
`include "core_params.svh"

module misc_settings (
   input  logic                 dsp_clk,
   input  logic                 por_rst,
   input  core_pkg::set_bus_t   set_i,
   input  logic                 run_tx_i,
   input  logic                 run_rx_i,
   input  logic                 clk_status_i,
   input  logic                 link_up_i,
   output core_pkg::ctrl_pins_t ctrl_o,
   output logic [7:0]           leds_o
);

   logic [4:0] clock_q;     // {ready, en[1:0], sel[1:0]}
   logic [3:0] serdes_q;
   logic [3:0] adc_q;
   logic       phy_rst_q;
   logic [7:0] led_sw_q;
   logic [7:0] led_src_q;
   logic [7:0] led_hw;

   ////////////////////////////////////////////////////////////////////////////
   // Register bank

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clock_q   <= '0;
         serdes_q  <= '0;
         adc_q     <= '0;
         phy_rst_q <= 1'b0;
         led_sw_q  <= '0;
         led_src_q <= `LED_SRC_RESET;
      end else if (set_i.stb) begin
         case (set_i.addr)
            `SR_CLK:     clock_q   <= set_i.data[4:0];
            `SR_SER:     serdes_q  <= set_i.data[3:0];
            `SR_ADC:     adc_q     <= set_i.data[3:0];
            `SR_LED_SW:  led_sw_q  <= set_i.data[7:0];
            `SR_PHY:     phy_rst_q <= set_i.data[0];
            `SR_LED_SRC: led_src_q <= set_i.data[7:0];
            default: ;   // Other units decode the rest
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Pin mapping

   assign ctrl_o.clock_ready = clock_q[4];
   assign ctrl_o.clk_en      = clock_q[3:2];
   assign ctrl_o.clk_sel     = clock_q[1:0];

   assign ctrl_o.ser_enable  = serdes_q[3];
   assign ctrl_o.ser_prbsen  = serdes_q[2];
   assign ctrl_o.ser_loopen  = serdes_q[1];
   assign ctrl_o.ser_rx_en   = serdes_q[0];

   assign ctrl_o.adc_oe_a    = adc_q[3];
   assign ctrl_o.adc_on_a    = adc_q[2];
   assign ctrl_o.adc_oe_b    = adc_q[1];
   assign ctrl_o.adc_on_b    = adc_q[0];

   assign ctrl_o.phy_resetn  = ~phy_rst_q;

   // Hardware indicators, bit 0 has no source
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, link_up_i, 1'b0};

   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

// File: hdl/radio_core_top.sv
/*
 * Control-plane core: Wishbone decoder, settings bus and readback.
 * One clock domain, driven by a single external Wishbone master.
 * Status inputs are assumed already synchronous to dsp_clk, except pps_i.
 */
`timescale 1ns/1ps

module radio_core_top (
   input  logic                 dsp_clk,
   input  logic                 por_rst,
   input  core_pkg::wb_req_t    wb_req_i,
   output core_pkg::wb_rsp_t    wb_rsp_o,
   input  logic                 pps_i,
   input  logic                 run_tx_i,
   input  logic                 run_rx_i,
   input  logic                 clk_status_i,
   input  logic                 link_up_i,
   input  logic                 button_i,
   output core_pkg::ctrl_pins_t ctrl_o,
   output logic [7:0]           leds_o
);

   import core_pkg::*;

   wb_req_t    set_req;
   wb_rsp_t    set_rsp;
   wb_req_t    rb_req;
   wb_rsp_t    rb_rsp;
   set_bus_t   set_bus;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;

   ////////////////////////////////////////////////////////////////////////////
   // Bus fabric

   wb_slave_decode u_decode (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .m_req_i(wb_req_i), .m_rsp_o(wb_rsp_o),
      .set_req_o(set_req), .set_rsp_i(set_rsp),
      .rb_req_o(rb_req), .rb_rsp_i(rb_rsp)
   );

   settings_bus u_settings_bus (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .wb_req_i(set_req), .wb_rsp_o(set_rsp), .set_o(set_bus)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Settings consumers

   misc_settings u_misc (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_i(set_bus),
      .run_tx_i(run_tx_i), .run_rx_i(run_rx_i),
      .clk_status_i(clk_status_i), .link_up_i(link_up_i),
      .ctrl_o(ctrl_o), .leds_o(leds_o)
   );

   vita_timer u_timer (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_i(set_bus), .pps_i(pps_i),
      .time_o(vita_time), .time_pps_o(vita_time_pps)
   );

   readback_mux u_readback (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .wb_req_i(rb_req), .wb_rsp_o(rb_rsp),
      .time_i(vita_time), .time_pps_i(vita_time_pps),
      .clk_status_i(clk_status_i), .link_up_i(link_up_i), .button_i(button_i)
   );

endmodule

// File: hdl/readback_mux.sv
/*
 * Wishbone read slave for status and time words.
 * Word index is byte address bits 4:2; data is registered with the ack.
 * Writes are acked and dropped. Time words are sampled independently,
 * so a high/low pair read in two cycles may straddle a carry.
 */
`timescale 1ns/1ps
`include "core_params.svh"

module readback_mux (
   input  logic                 dsp_clk,
   input  logic                 por_rst,
   input  core_pkg::wb_req_t    wb_req_i,
   output core_pkg::wb_rsp_t    wb_rsp_o,
   input  core_pkg::vita_time_t time_i,
   input  core_pkg::vita_time_t time_pps_i,
   input  logic                 clk_status_i,
   input  logic                 link_up_i,
   input  logic                 button_i
);

   localparam int IDX_W = $clog2(`RB_WORDS);

   logic [31:0]      words [`RB_WORDS];
   logic [IDX_W-1:0] idx;
   logic             ack_q;
   logic [31:0]      dat_q;

   assign words[0] = time_i[63:32];
   assign words[1] = time_i[31:0];
   assign words[2] = time_pps_i[63:32];
   assign words[3] = time_pps_i[31:0];
   assign words[4] = `COMPAT_NUM;
   assign words[5] = {18'b0, button_i, 1'b0, clk_status_i, link_up_i, 10'b0};
   assign words[6] = '0;
   assign words[7] = '0;

   assign idx = wb_req_i.adr[IDX_W+1:2];

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= wb_req_i.cyc & wb_req_i.stb & ~ack_q;
      end
   end

   always_ff @(posedge dsp_clk) begin
      dat_q <= words[idx];
   end

   assign wb_rsp_o.ack = ack_q;
   assign wb_rsp_o.err = 1'b0;
   assign wb_rsp_o.dat = dat_q;

endmodule

// File: hdl/settings_bus.sv
/*
 * Wishbone write slave feeding the settings bus.
 * Every access is acked; reads return zero.
 * A write produces one stb pulse, on the same edge as its ack.
 */
`timescale 1ns/1ps

module settings_bus (
   input  logic               dsp_clk,
   input  logic               por_rst,
   input  core_pkg::wb_req_t  wb_req_i,
   output core_pkg::wb_rsp_t  wb_rsp_o,
   output core_pkg::set_bus_t set_o
);

   logic        ack_q;
   logic        stb_q;
   logic [7:0]  addr_q;
   logic [31:0] data_q;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         ack_q <= 1'b0;
         stb_q <= 1'b0;
      end else begin
         ack_q <= wb_req_i.cyc & wb_req_i.stb & ~ack_q;
         stb_q <= wb_req_i.cyc & wb_req_i.stb & wb_req_i.we & ~ack_q;
      end
   end

   always_ff @(posedge dsp_clk) begin
      addr_q <= wb_req_i.adr[9:2];   // Word address within the window
      data_q <= wb_req_i.dat;
   end

   assign wb_rsp_o.ack = ack_q;
   assign wb_rsp_o.err = 1'b0;
   assign wb_rsp_o.dat = '0;

   assign set_o.stb  = stb_q;
   assign set_o.addr = addr_q;
   assign set_o.data = data_q;

endmodule

// File: hdl/vita_timer.sv
/*
 * 64-bit timekeeper, one count per dsp_clk cycle.
 * Software writes the high word first; the low-word write loads both.
 * pps_i is asynchronous; the count is latched on the fourth edge after
 * it rises. No PPS qualification or missing-pulse detection.
 */
`timescale 1ns/1ps
`include "core_params.svh"

module vita_timer (
   input  logic                 dsp_clk,
   input  logic                 por_rst,
   input  core_pkg::set_bus_t   set_i,
   input  logic                 pps_i,
   output core_pkg::vita_time_t time_o,
   output core_pkg::vita_time_t time_pps_o
);

   import core_pkg::*;

   vita_time_t  time_q;
   vita_time_t  time_pps_q;
   logic [31:0] load_hi_q;
   logic [1:0]  pps_sync;
   logic        pps_dly;
   logic        pps_rise_q;

   ////////////////////////////////////////////////////////////////////////////
   // Counter and software load

   always_ff @(posedge dsp_clk) begin
      if (set_i.stb && set_i.addr == `SR_TIME_HI) begin
         load_hi_q <= set_i.data;   // Held until the low word arrives
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_q <= '0;
      end else if (set_i.stb && set_i.addr == `SR_TIME_LO) begin
         time_q <= {load_hi_q, set_i.data};
      end else begin
         time_q <= time_q + 64'd1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // PPS capture

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_sync   <= '0;
         pps_dly    <= 1'b0;
         pps_rise_q <= 1'b0;
      end else begin
         pps_sync   <= {pps_sync[0], pps_i};        // Two-flop synchronizer
         pps_dly    <= pps_sync[1];
         pps_rise_q <= pps_sync[1] & ~pps_dly;     // Registered rising edge
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_pps_q <= '0;
      end else if (pps_rise_q) begin
         time_pps_q <= time_q;
      end
   end

   assign time_o     = time_q;
   assign time_pps_o = time_pps_q;

endmodule

// File: hdl/wb_slave_decode.sv
/*
 * Single-master Wishbone decoder with two slave windows.
 * Only the selected slave sees cyc and stb; the others see them low.
 * Addresses outside both windows end with a registered one-cycle err.
 * Assumes the master holds its request until ack or err.
 */
`timescale 1ns/1ps
`include "core_params.svh"

module wb_slave_decode (
   input  logic              dsp_clk,
   input  logic              por_rst,
   input  core_pkg::wb_req_t m_req_i,
   output core_pkg::wb_rsp_t m_rsp_o,
   output core_pkg::wb_req_t set_req_o,
   input  core_pkg::wb_rsp_t set_rsp_i,
   output core_pkg::wb_req_t rb_req_o,
   input  core_pkg::wb_rsp_t rb_rsp_i
);

   logic set_hit;
   logic rb_hit;
   logic miss;
   logic err_q;

   assign set_hit = ((m_req_i.adr & `MASK_SETTINGS) == `ADR_SETTINGS);
   assign rb_hit  = ((m_req_i.adr & `MASK_READBACK) == `ADR_READBACK);
   assign miss    = ~set_hit & ~rb_hit;

   ////////////////////////////////////////////////////////////////////////////
   // Request fan-out

   always_comb begin
      set_req_o     = m_req_i;
      set_req_o.cyc = m_req_i.cyc & set_hit;
      set_req_o.stb = m_req_i.stb & set_hit;

      rb_req_o      = m_req_i;
      rb_req_o.cyc  = m_req_i.cyc & rb_hit;
      rb_req_o.stb  = m_req_i.stb & rb_hit;
   end

   // Bus error for unmapped cycles, same timing as a slave ack
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         err_q <= 1'b0;
      end else begin
         err_q <= m_req_i.cyc & m_req_i.stb & miss & ~err_q;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Response mux

   always_comb begin
      if (set_hit) begin
         m_rsp_o = set_rsp_i;
      end else if (rb_hit) begin
         m_rsp_o = rb_rsp_i;
      end else begin
         m_rsp_o.ack = 1'b0;
         m_rsp_o.err = err_q;
         m_rsp_o.dat = '0;
      end
   end

endmodule

// File: include/core_params.svh
/*
 * Address map, setting addresses and constants of the control-plane core.
 * Windows are matched on the 16-bit byte address with a mask.
 * Setting addresses are 8 bits wide and taken from byte address bits 9:2.
 */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Wishbone address windows

// Settings bus owns 0x7000 to 0x7FFF, only the low 1K is decoded
`define ADR_SETTINGS    16'h7000
`define MASK_SETTINGS   16'hF000

// Readback words live in 0x5C00 to 0x5FFF
`define ADR_READBACK    16'h5C00
`define MASK_READBACK   16'hFC00

////////////////////////////////////////////////////////////////////////////
// Settings bus addresses

`define SR_MISC         8'd0
`define SR_CLK          (`SR_MISC + 8'd0)   // Clock chip control
`define SR_SER          (`SR_MISC + 8'd1)   // SERDES control
`define SR_ADC          (`SR_MISC + 8'd2)   // ADC enables
`define SR_LED_SW       (`SR_MISC + 8'd3)
`define SR_PHY          (`SR_MISC + 8'd4)   // 1 holds the PHY in reset
`define SR_LED_SRC      (`SR_MISC + 8'd6)   // 1 = hardware, 0 = software

`define SR_TIME64       8'd10
`define SR_TIME_HI      (`SR_TIME64 + 8'd0)
`define SR_TIME_LO      (`SR_TIME64 + 8'd1) // Load happens on this one

////////////////////////////////////////////////////////////////////////////
// Reset values and readback

`define LED_SRC_RESET   8'h1E

// Bump when the register map changes; major in the top half
`define COMPAT_NUM      {16'd8, 16'd2}

`define RB_WORDS        8

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the control-core testbench with Verilator and runs it from the project root.
# The result is taken from the simulation log, not from the simulator's exit status.
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module radio_core_tb -Mdir obj_dir -o radio_core_sim -f sources.f \
   && ./obj_dir/radio_core_sim 2>&1 | tee sim.log \
   || echo "Build or simulation ended with an error"

grep -qx "TB PASSED" sim.log && echo "Result: pass" || { echo "Result: fail"; exit 1; }

// File: sources.f
+incdir+include
hdl/core_pkg.sv
hdl/wb_slave_decode.sv
hdl/settings_bus.sv
hdl/misc_settings.sv
hdl/vita_timer.sv
hdl/readback_mux.sv
hdl/radio_core_top.sv
dv/radio_core_assertions.sv
dv/radio_core_tb.sv
